//--- verilog/smurf_config.svh
`ifndef SMURF_CONFIG_SVH
`define SMURF_CONFIG_SVH

// word geometry
`define SMURF_WIDTH   16
`define SMURF_BITWDTH 4   // bits to index one data bit

// address space, valid words stop short of 2**BITADDR
`define SMURF_NUMADDR 1000
`define SMURF_BITADDR 10

`endif

//--- verilog/smurf_pkg.sv
`include "smurf_config.svh"

package smurf_pkg;

  // operation of one bank port
  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_READ,
    BANK_WRITE
  } bank_op_e;

  typedef enum logic {
    SHADOW_INVALID,
    SHADOW_VALID
  } shadow_state_e;

  // **************************************************
  // port requests, as seen at the top level
  // **************************************************
  typedef struct packed {
    logic                      write;
    logic [`SMURF_BITADDR-1:0] adr;
    logic [`SMURF_WIDTH-1:0]   din;
    logic [`SMURF_WIDTH-1:0]   bw;    // bit write mask
  } wr_req_t;

  typedef struct packed {
    logic                      read;
    logic [`SMURF_BITADDR-1:0] adr;
  } rd_req_t;

  // **************************************************
  // internal and result types
  // **************************************************
  typedef struct packed {
    bank_op_e                  op;
    logic [`SMURF_BITADDR-1:0] adr;
    logic [`SMURF_WIDTH-1:0]   din;
    logic [`SMURF_WIDTH-1:0]   bw;
  } bank_cmd_t;

  typedef struct packed {
    logic                    vld;
    logic [`SMURF_WIDTH-1:0] dout;
  } rd_res_t;

endpackage

//--- verilog/smurf_decode.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module smurf_decode
  import smurf_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  rd_req_t   rd_req,
  input  wr_req_t   wr_req0,
  input  wr_req_t   wr_req1,
  output bank_cmd_t cmd_a,
  output bank_cmd_t cmd_b,
  output bank_cmd_t cmd_c
);

  logic wr0_ok;
  logic wr1_ok;
  logic rd_ok;

  // the only range check in the design
  function automatic logic in_range(input logic [`SMURF_BITADDR-1:0] adr);
    return adr < `SMURF_NUMADDR;
  endfunction

  assign wr0_ok = wr_req0.write && in_range(wr_req0.adr);
  assign wr1_ok = wr_req1.write && in_range(wr_req1.adr);
  assign rd_ok  = rd_req.read && in_range(rd_req.adr);

  // **************************************************
  // request register
  // **************************************************
  always_ff @(posedge clk) begin
    // payload follows the ports every cycle
    cmd_a.adr <= wr_req0.adr;
    cmd_a.din <= wr_req0.din;
    cmd_a.bw  <= wr_req0.bw;

    cmd_b.adr <= wr_req1.adr;
    cmd_b.din <= wr_req1.din;
    cmd_b.bw  <= wr_req1.bw;

    cmd_c.adr <= rd_req.adr;
    cmd_c.din <= '0;               // read port carries no data
    cmd_c.bw  <= '0;

    if (rst) begin
      cmd_a.op <= BANK_IDLE;
      cmd_b.op <= BANK_IDLE;
      cmd_c.op <= BANK_IDLE;
    end else begin
      cmd_a.op <= wr0_ok ? BANK_WRITE : BANK_IDLE;
      cmd_b.op <= wr1_ok ? BANK_WRITE : BANK_IDLE;
      cmd_c.op <= rd_ok ? BANK_READ : BANK_IDLE;   // out of range reads vanish here
    end
  end

endmodule

//--- verilog/smurf_bank.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module smurf_bank
  import smurf_pkg::*;
(
  input  logic                    clk,
  input  bank_cmd_t               cmd_a,
  input  bank_cmd_t               cmd_b,
  input  bank_cmd_t               cmd_c,
  output logic [`SMURF_WIDTH-1:0] bank_dout,
  output logic                    bank_rd
);

  logic [`SMURF_WIDTH-1:0] mem [0:`SMURF_NUMADDR-1];

  logic                    wr_a;
  logic                    wr_b;
  logic [`SMURF_WIDTH-1:0] word_a;
  logic [`SMURF_WIDTH-1:0] base_b;
  logic [`SMURF_WIDTH-1:0] word_b;

  function automatic logic [`SMURF_WIDTH-1:0] merge_word(
    input logic [`SMURF_WIDTH-1:0] old_word,
    input logic [`SMURF_WIDTH-1:0] din,
    input logic [`SMURF_WIDTH-1:0] bw
  );
    return (old_word & ~bw) | (din & bw);
  endfunction

  assign wr_a = (cmd_a.op == BANK_WRITE);
  assign wr_b = (cmd_b.op == BANK_WRITE);

  // **************************************************
  // masked write merge, port B lands on top of port A
  // **************************************************
  assign word_a = merge_word(mem[cmd_a.adr], cmd_a.din, cmd_a.bw);

  // same word on both ports: B starts from A's result
  assign base_b = (wr_a && (cmd_a.adr == cmd_b.adr)) ? word_a : mem[cmd_b.adr];
  assign word_b = merge_word(base_b, cmd_b.din, cmd_b.bw);

  always_ff @(posedge clk) begin
    if (wr_a) begin
      mem[cmd_a.adr] <= word_a;
    end
    if (wr_b) begin
      mem[cmd_b.adr] <= word_b;   // later assignment wins on a shared address
    end
  end

  // **************************************************
  // read port C, old data on a same cycle write
  // **************************************************
  always_ff @(posedge clk) begin
    bank_rd <= (cmd_c.op == BANK_READ);
    if (cmd_c.op == BANK_READ) begin
      bank_dout <= mem[cmd_c.adr];
    end
  end

endmodule

//--- verilog/smurf_result.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module smurf_result
  import smurf_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`SMURF_WIDTH-1:0] bank_dout,
  input  logic                    bank_rd,
  output rd_res_t                 rd_res
);

  // output register of the read path
  always_ff @(posedge clk) begin
    if (bank_rd) begin
      rd_res.dout <= bank_dout;    // hold between reads
    end

    if (rst) begin
      rd_res.vld <= 1'b0;
    end else begin
      rd_res.vld <= bank_rd;
    end
  end

endmodule

//--- verilog/smurf_bit_monitor.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module smurf_bit_monitor
  import smurf_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`SMURF_BITADDR-1:0] select_addr,
  input  logic [`SMURF_BITWDTH-1:0] select_bit,
  input  bank_cmd_t                 cmd_a,
  input  bank_cmd_t                 cmd_b,
  input  bank_cmd_t                 cmd_c,
  input  rd_res_t                   rd_res,
  output logic                      mon_error
);

  // one in-flight read of the selected word
  typedef struct packed {
    logic check;
    logic exp_bit;
  } chk_t;

  shadow_state_e state;
  logic          shadow;
  logic          hit_a;
  logic          hit_b;
  logic          hit_c;
  chk_t          chk_p [0:1];

  assign hit_a = (cmd_a.op == BANK_WRITE) && (cmd_a.adr == select_addr) &&
                 cmd_a.bw[select_bit];
  assign hit_b = (cmd_b.op == BANK_WRITE) && (cmd_b.adr == select_addr) &&
                 cmd_b.bw[select_bit];
  assign hit_c = (cmd_c.op == BANK_READ) && (cmd_c.adr == select_addr);

  // **************************************************
  // shadow copy updated alongside the bank write
  // **************************************************
  always_ff @(posedge clk) begin
    if (hit_b) begin
      shadow <= cmd_b.din[select_bit];
    end else if (hit_a) begin
      shadow <= cmd_a.din[select_bit];
    end

    if (rst) begin
      state <= SHADOW_INVALID;
    end else if (hit_a || hit_b) begin
      state <= SHADOW_VALID;
    end
  end

  // captured at the bank read and carried through bank and result
  always_ff @(posedge clk) begin
    chk_p[0].exp_bit <= shadow;
    chk_p[1].exp_bit <= chk_p[0].exp_bit;

    if (rst) begin
      chk_p[0].check <= 1'b0;
      chk_p[1].check <= 1'b0;
      mon_error      <= 1'b0;
    end else begin
      chk_p[0].check <= hit_c && (state == SHADOW_VALID);
      chk_p[1].check <= chk_p[0].check;
      if (rd_res.vld && chk_p[1].check &&
          (rd_res.dout[select_bit] != chk_p[1].exp_bit)) begin
        mon_error <= 1'b1;         // sticky until reset
      end
    end
  end

endmodule

//--- verilog/smurf_1r2w.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module smurf_1r2w
  import smurf_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  rd_req_t                   rd_req,
  input  wr_req_t                   wr_req0,
  input  wr_req_t                   wr_req1,
  input  logic [`SMURF_BITADDR-1:0] select_addr,
  input  logic [`SMURF_BITWDTH-1:0] select_bit,
  output rd_res_t                   rd_res,
  output logic                      mon_error
);

  bank_cmd_t               cmd_a;    // write port 0
  bank_cmd_t               cmd_b;    // write port 1
  bank_cmd_t               cmd_c;    // read port
  logic [`SMURF_WIDTH-1:0] bank_dout;
  logic                    bank_rd;

  // **************************************************
  // data path: decode, bank, result
  // **************************************************
  smurf_decode decode_inst (
    .clk     (clk),
    .rst     (rst),
    .rd_req  (rd_req),
    .wr_req0 (wr_req0),
    .wr_req1 (wr_req1),
    .cmd_a   (cmd_a),
    .cmd_b   (cmd_b),
    .cmd_c   (cmd_c)
  );

  smurf_bank bank_inst (
    .clk       (clk),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .cmd_c     (cmd_c),
    .bank_dout (bank_dout),
    .bank_rd   (bank_rd)
  );

  smurf_result result_inst (
    .clk       (clk),
    .rst       (rst),
    .bank_dout (bank_dout),
    .bank_rd   (bank_rd),
    .rd_res    (rd_res)
  );

  // integrity check of one selected bit
  smurf_bit_monitor monitor_inst (
    .clk         (clk),
    .rst         (rst),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .cmd_a       (cmd_a),
    .cmd_b       (cmd_b),
    .cmd_c       (cmd_c),
    .rd_res      (rd_res),
    .mon_error   (mon_error)
  );

endmodule

//--- tests/tb_smurf_1r2w.sv
`timescale 1ns/1ps
`include "smurf_config.svh"

module tb_smurf_1r2w
  import smurf_pkg::*;
();

  localparam int                        TIMEOUT_CYCLES = 4000;
  localparam logic [`SMURF_BITADDR-1:0] SEL_ADR        = 10'd37;
  localparam logic [`SMURF_BITWDTH-1:0] SEL_BIT        = 4'd9;
  localparam rd_req_t                   RD_IDLE        = '0;
  localparam wr_req_t                   WR_IDLE        = '0;

  typedef struct packed {
    logic [31:0]             due;     // cycle in which rd_res must carry it
    logic [`SMURF_WIDTH-1:0] data;
  } exp_read_t;

  logic                      clk = 1'b0;
  logic                      rst;
  rd_req_t                   rd_req;
  wr_req_t                   wr_req0;
  wr_req_t                   wr_req1;
  logic [`SMURF_BITADDR-1:0] select_addr;
  logic [`SMURF_BITWDTH-1:0] select_bit;
  rd_res_t                   rd_res;
  logic                      mon_error;

  int                        cyc = 0;
  integer                    seed = 32'hb191;
  logic [`SMURF_WIDTH-1:0]   ref_mem [int];   // reference copy of the memory
  exp_read_t                 exp_q [$];

  smurf_1r2w smurf_1r2w_inst (
    .clk         (clk),
    .rst         (rst),
    .rd_req      (rd_req),
    .wr_req0     (wr_req0),
    .wr_req1     (wr_req1),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .rd_res      (rd_res),
    .mon_error   (mon_error)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYCLES) begin
      $display("timeout reached after %0d cycles, tests did not finish", cyc);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  // **************************************************
  // compare tasks
  // **************************************************
  task automatic check_res(input rd_res_t got, input rd_res_t exp, input string what);
    if ((got.vld !== exp.vld) || (exp.vld && (got.dout !== exp.dout))) begin
      $display("FAIL %0t: %s, got vld %b dout %h, expected vld %b dout %h",
               $time, what, got.vld, got.dout, exp.vld, exp.dout);
      $display("Test failed");
      $fatal(1, "rd_res mismatch");
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t: mon_error is %b, expected %b", $time, got, exp);
      $display("Test failed");
      $fatal(1, "mon_error mismatch");
    end
  endtask

  // **************************************************
  // cycle driver and reference model
  // **************************************************
  function automatic wr_req_t write_req(input logic [`SMURF_BITADDR-1:0] adr,
                                        input logic [`SMURF_WIDTH-1:0] din,
                                        input logic [`SMURF_WIDTH-1:0] bw);
    write_req = '{write: 1'b1, adr: adr, din: din, bw: bw};
  endfunction

  function automatic rd_req_t read_req(input logic [`SMURF_BITADDR-1:0] adr);
    read_req = '{read: 1'b1, adr: adr};
  endfunction

  // every outputs check happens here, once per cycle
  task automatic advance_cycle();
    rd_res_t   exp;
    exp_read_t entry;
    @(posedge clk);
    #1;
    exp = '0;
    if ((exp_q.size() > 0) && (exp_q[0].due == cyc)) begin
      entry    = exp_q.pop_front();
      exp.vld  = 1'b1;
      exp.dout = entry.data;
    end
    check_res(rd_res, exp, "read result");
    check_error(mon_error, 1'b0);
  endtask

  task automatic apply_write(input wr_req_t w);
    logic [`SMURF_WIDTH-1:0] word;
    if (w.write && (w.adr < `SMURF_NUMADDR)) begin
      word = ref_mem.exists(w.adr) ? ref_mem[w.adr] : 'x;
      for (int i = 0; i < `SMURF_WIDTH; i++) begin
        if (w.bw[i]) word[i] = w.din[i];
      end
      ref_mem[w.adr] = word;
    end
  endtask

  task automatic drive_cycle(input rd_req_t r, input wr_req_t w0, input wr_req_t w1);
    exp_read_t entry;
    advance_cycle();
    if (r.read && (r.adr < `SMURF_NUMADDR)) begin
      entry.due  = cyc + 3;          // decode, bank, result registers
      entry.data = ref_mem[r.adr];   // taken before this cycle's writes
      exp_q.push_back(entry);
    end
    apply_write(w0);
    apply_write(w1);                 // port 1 on top of port 0
    rd_req  = r;
    wr_req0 = w0;
    wr_req1 = w1;
  endtask

  task automatic drain_pipeline();
    repeat (4) drive_cycle(RD_IDLE, WR_IDLE, WR_IDLE);
  endtask

  // **************************************************
  // directed tests
  // **************************************************
  task automatic basic_write_read();
    logic [`SMURF_BITADDR-1:0] adrs [0:15];
    rd_res_t                   idle_res;
    idle_res = '0;
    check_res(rd_res, idle_res, "vld after reset");
    check_error(mon_error, 1'b0);
    for (int i = 0; i < 16; i++) begin
      adrs[i] = {$random(seed)} % `SMURF_NUMADDR;
      if (i % 2 == 0) drive_cycle(RD_IDLE, write_req(adrs[i], $random(seed), '1), WR_IDLE);
      else drive_cycle(RD_IDLE, WR_IDLE, write_req(adrs[i], $random(seed), '1));
    end
    for (int i = 0; i < 16; i++) drive_cycle(read_req(adrs[i]), WR_IDLE, WR_IDLE);
    drain_pipeline();
  endtask

  task automatic masked_writes();
    logic [`SMURF_BITADDR-1:0] adr;
    for (int i = 0; i < 8; i++) begin
      adr = {$random(seed)} % `SMURF_NUMADDR;
      drive_cycle(RD_IDLE, write_req(adr, $random(seed), '1), WR_IDLE);
      drive_cycle(RD_IDLE, write_req(adr, $random(seed), $random(seed)), WR_IDLE);
      drive_cycle(read_req(adr), write_req(adr, $random(seed), $random(seed)),
                  write_req(adr, $random(seed), $random(seed)));   // merge of both ports
      drive_cycle(read_req(adr), WR_IDLE, WR_IDLE);
    end
    drain_pipeline();
  endtask

  task automatic same_cycle_order();
    logic [`SMURF_BITADDR-1:0] adr;
    adr = {$random(seed)} % `SMURF_NUMADDR;
    drive_cycle(RD_IDLE, write_req(adr, $random(seed), '1), WR_IDLE);
    drive_cycle(read_req(adr), write_req(adr, $random(seed), '1), WR_IDLE);   // old word
    drive_cycle(read_req(adr), WR_IDLE, WR_IDLE);                             // new word
    drive_cycle(read_req(adr), WR_IDLE, write_req(adr, $random(seed), '1));
    drive_cycle(read_req(adr), WR_IDLE, WR_IDLE);
    drain_pipeline();
  endtask

  task automatic back_to_back_reads();
    logic [`SMURF_BITADDR-1:0] base;
    base = {$random(seed)} % (`SMURF_NUMADDR - 20);
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) drive_cycle(RD_IDLE, write_req(base + i, $random(seed), '1), WR_IDLE);
      else drive_cycle(RD_IDLE, WR_IDLE, write_req(base + i, $random(seed), '1));
    end
    for (int i = 0; i < 20; i++) drive_cycle(read_req(base + i), WR_IDLE, WR_IDLE);
    drain_pipeline();
  endtask

  task automatic out_of_range();
    logic [`SMURF_BITADDR-1:0] adr;
    logic [`SMURF_BITADDR-1:0] bad;
    adr = {$random(seed)} % `SMURF_NUMADDR;
    drive_cycle(RD_IDLE, write_req(adr, $random(seed), '1), WR_IDLE);
    for (int i = 0; i < 6; i++) begin
      bad = (i == 5) ? 10'd1023 : `SMURF_NUMADDR + ({$random(seed)} % 24);
      drive_cycle(read_req(bad), write_req(bad, $random(seed), '1),
                  write_req(bad, $random(seed), '1));   // all dropped, no vld
    end
    drive_cycle(read_req(adr), WR_IDLE, WR_IDLE);
    drain_pipeline();
  endtask

  task automatic monitor_bit();
    logic [`SMURF_WIDTH-1:0] sel_mask;
    sel_mask = 1 << SEL_BIT;
    drive_cycle(RD_IDLE, write_req(SEL_ADR, $random(seed), '1), WR_IDLE);
    drive_cycle(read_req(SEL_ADR), WR_IDLE, write_req(SEL_ADR, $random(seed), sel_mask));
    drive_cycle(read_req(SEL_ADR), write_req(SEL_ADR, $random(seed), sel_mask),
                write_req(SEL_ADR, $random(seed), sel_mask | $random(seed)));
    drive_cycle(read_req(SEL_ADR), write_req(SEL_ADR, $random(seed), ~sel_mask), WR_IDLE);
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) drive_cycle(read_req(SEL_ADR), write_req(SEL_ADR, $random(seed), sel_mask),
                                  WR_IDLE);
      else drive_cycle(read_req(SEL_ADR), WR_IDLE, write_req(SEL_ADR, $random(seed), sel_mask));
    end
    drain_pipeline();
    check_error(mon_error, 1'b0);
  endtask

  initial begin
    rst         = 1'b1;
    rd_req      = RD_IDLE;
    wr_req0     = WR_IDLE;
    wr_req1     = WR_IDLE;
    select_addr = SEL_ADR;
    select_bit  = SEL_BIT;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    basic_write_read();
    masked_writes();
    same_cycle_order();
    back_to_back_reads();
    out_of_range();
    monitor_bit();

    if (exp_q.size() != 0) begin
      $display("%0d expected read results never arrived", exp_q.size());
      $display("Test failed");
      $fatal(1, "reads missing");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- smurf_1r2w.f
+incdir+verilog
verilog/smurf_pkg.sv
verilog/smurf_decode.sv
verilog/smurf_bank.sv
verilog/smurf_result.sv
verilog/smurf_bit_monitor.sv
verilog/smurf_1r2w.sv
tests/tb_smurf_1r2w.sv
